// File: design/vdp_pkg.sv
// ********************************************************************
// vdp shared definitions
// ********************************************************************

package vdp_pkg;

    typedef logic [3:0] color_t;            // color index, no palette behind it
    typedef logic [7:0] vdp_byte_t;         // cpu bus and register byte

    // width of the raster counters, enough for lines of up to 1024 clocks
    localparam int HV_W = 10;

    // ********************************************************************
    // register file
    // ********************************************************************
    localparam logic [2:0] REG_CTRL     = 3'd1;
    localparam int         CTRL_BLANK_N = 6;   // set to show the bitmap
    localparam int         CTRL_IE      = 5;   // set to route the frame flag to irq

    localparam logic [2:0] REG_BACKDROP = 3'd7;   // low nibble is the backdrop color

    // second control byte, the bits that pick the command
    localparam int CMD_REG_BIT   = 7;
    localparam int CMD_WRITE_BIT = 6;

    // status byte layout
    localparam int STAT_FRAME_BIT = 7;

endpackage

// File: design/cpu_bus_sync.sv
// ********************************************************************
// cpu strobe synchronizer
// ********************************************************************

`timescale 1ns/1ps

module cpu_bus_sync import vdp_pkg::*; #(
    parameter int SYN_LEN = 3                // 3 or more, the pre-tick needs bit 2
) (
    input  logic      pxclk,
    input  logic      reset,
    input  logic      cpu_mode,              // port select, stable during the strobe
    input  vdp_byte_t cpu_din,
    input  logic      cpu_wr,                // async write strobe
    input  logic      cpu_rd,                // async read strobe
    input  vdp_byte_t dout,                  // read value from the port logic
    output vdp_byte_t cpu_dout,
    output logic      wr_tick,
    output logic      rd_tick,
    output logic      mode,
    output vdp_byte_t din
);

    logic [SYN_LEN-1:0] wr_sync;             // newest sample sits in the msb
    logic [SYN_LEN-1:0] rd_sync;
    logic               wr_pre;
    logic               rd_pre;

    // shift the strobes down toward bit 0
    always_ff @(posedge pxclk) begin
        if (reset) begin
            wr_sync <= '0;
            rd_sync <= '0;
        end else begin
            wr_sync <= {cpu_wr, wr_sync[SYN_LEN-1:1]};
            rd_sync <= {cpu_rd, rd_sync[SYN_LEN-1:1]};
        end
    end

    assign wr_tick = (wr_sync[1:0] == 2'b10);   // rising edge reached the end of the chain
    assign rd_tick = (rd_sync[1:0] == 2'b10);

    // the same edge one stage earlier, so the bus values are loaded one
    // clock before the tick sees them
    assign wr_pre = (wr_sync[2:1] == 2'b10);
    assign rd_pre = (rd_sync[2:1] == 2'b10);

    // the cpu holds mode and data for the whole strobe, so a plain enable
    // is safe here even though the buses are not synchronized
    always_ff @(posedge pxclk) begin
        if (wr_pre || rd_pre) begin
            mode <= cpu_mode;                // a status read needs mode too
        end
        if (wr_pre) begin
            din <= cpu_din;
        end
    end

    // half a clock earlier than the rising edge gives the cpu more setup
    always_ff @(negedge pxclk) begin
        if (reset) begin
            cpu_dout <= '0;
        end else if (rd_tick) begin
            cpu_dout <= dout;                // held until the next read
        end
    end

endmodule

// File: design/vdp_port.sv
// ********************************************************************
// vdp cpu port, registers and status
// ********************************************************************

`timescale 1ns/1ps

module vdp_port import vdp_pkg::*; #(
    parameter int VRAM_AW = 14
) (
    input  logic               pxclk,
    input  logic               reset,
    input  logic               wr_tick,
    input  logic               rd_tick,
    input  logic               mode,         // 1 for control and status, 0 for data
    input  vdp_byte_t          din,
    input  logic               frame_start,
    input  logic               port_gnt,
    input  logic               port_ack,
    input  logic [7:0]         vram_rdata,
    output vdp_byte_t          dout,
    output logic               irq,
    output logic               port_req,
    output logic               port_we,
    output logic [VRAM_AW-1:0] port_addr,
    output logic [7:0]         port_wdata,
    output logic               display_on,
    output color_t             backdrop
);

    vdp_byte_t          first_byte;          // first half of a control pair
    vdp_byte_t          read_ahead;          // next byte a data read returns
    logic               second;              // the next control byte completes a pair
    logic               irq_en;
    logic               frame_flag;
    logic [VRAM_AW-1:0] addr;                // auto-incrementing vram pointer
    logic [13:0]        setup_addr;
    logic [VRAM_AW-1:0] acc_addr;
    logic wr_ctrl, wr_data, rd_data, rd_stat;
    logic reg_wr, wr_setup, rd_setup, access;

    // ********************************************************************
    // command decode
    // ********************************************************************
    assign wr_ctrl = wr_tick & mode;
    assign wr_data = wr_tick & ~mode;
    assign rd_data = rd_tick & ~mode;
    assign rd_stat = rd_tick & mode;

    assign reg_wr   = wr_ctrl & second & din[CMD_REG_BIT];
    assign wr_setup = wr_ctrl & second & ~din[CMD_REG_BIT] & din[CMD_WRITE_BIT];
    assign rd_setup = wr_ctrl & second & ~din[CMD_REG_BIT] & ~din[CMD_WRITE_BIT];

    assign setup_addr = {din[5:0], first_byte};   // low byte came first
    assign access     = wr_data | rd_data | rd_setup;   // each of these touches vram
    assign acc_addr   = rd_setup ? setup_addr[VRAM_AW-1:0] : addr;

    always_ff @(posedge pxclk) begin
        if (reset) begin
            second     <= 1'b0;
            addr       <= '0;
            display_on <= 1'b0;
            irq_en     <= 1'b0;
            backdrop   <= '0;
            frame_flag <= 1'b0;
            port_req   <= 1'b0;
            port_we    <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                second <= ~second;
            end else if (rd_stat) begin
                second <= 1'b0;              // a status read restarts the pair
            end

            if (reg_wr) begin
                case (din[2:0])
                    REG_CTRL: begin
                        display_on <= first_byte[CTRL_BLANK_N];
                        irq_en     <= first_byte[CTRL_IE];
                    end
                    REG_BACKDROP: backdrop <= first_byte[3:0];
                    default: ;               // registers the bitmap mode has no use for
                endcase
            end

            if (access) begin
                addr <= acc_addr + 1'b1;     // the read setup also steps past its byte
            end else if (wr_setup) begin
                addr <= setup_addr[VRAM_AW-1:0];
            end

            // one request in flight, ticks are far enough apart for that
            if (access) begin
                port_req <= 1'b1;
                port_we  <= wr_data;
            end else if (port_gnt) begin
                port_req <= 1'b0;
            end

            if (frame_start) begin
                frame_flag <= 1'b1;          // a new frame wins over a clearing read
            end else if (rd_stat) begin
                frame_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge pxclk) begin
        if (wr_ctrl && !second) begin
            first_byte <= din;
        end
        if (access) begin
            port_addr  <= acc_addr;
            port_wdata <= din;
        end
        if (port_ack && !port_we) begin
            read_ahead <= vram_rdata;        // refill after a data read or read setup
        end
    end

    // the read value is sampled during rd_tick, before the flag clears
    always_comb begin
        if (mode) begin
            dout                 = '0;
            dout[STAT_FRAME_BIT] = frame_flag;
        end else begin
            dout = read_ahead;
        end
    end

    assign irq = frame_flag & irq_en;

endmodule

// File: design/vram_arbiter.sv
// ********************************************************************
// vram array and arbiter
// ********************************************************************

`timescale 1ns/1ps

module vram_arbiter #(
    parameter int VRAM_AW = 14
) (
    input  logic               pxclk,
    input  logic               fetch_req,
    input  logic [VRAM_AW-1:0] fetch_addr,
    input  logic               port_req,
    input  logic               port_we,
    input  logic [VRAM_AW-1:0] port_addr,
    input  logic [7:0]         port_wdata,
    output logic               fetch_gnt,
    output logic               fetch_ack,
    output logic               port_gnt,
    output logic               port_ack,
    output logic [7:0]         vram_rdata
);

    logic [7:0]         mem [2**VRAM_AW];   // single port, one access per clock
    logic [VRAM_AW-1:0] mem_addr;

    // the display cannot wait, so the fetch always wins
    assign fetch_gnt = fetch_req;
    assign port_gnt  = port_req & ~fetch_req;   // the fetch leaves every other cycle free

    assign mem_addr = fetch_req ? fetch_addr : port_addr;

    always_ff @(posedge pxclk) begin
        if (port_gnt && port_we) begin
            mem[port_addr] <= port_wdata;
        end
        if (fetch_gnt || port_gnt) begin
            vram_rdata <= mem[mem_addr];     // old contents on a write, nobody takes them
        end
    end

    // acks mark whose data sits on vram_rdata, one clock after the grant
    always_ff @(posedge pxclk) begin
        fetch_ack <= fetch_gnt;
        port_ack  <= port_gnt;
    end

endmodule

// File: design/video_timing.sv
// ********************************************************************
// raster timing
// ********************************************************************

`timescale 1ns/1ps

module video_timing import vdp_pkg::*; #(
    parameter int H_ACTIVE = 256,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 32,
    parameter int H_BACK   = 38,
    parameter int V_ACTIVE = 128,
    parameter int V_FRONT  = 24,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 13
) (
    input  logic            pxclk,
    input  logic            reset,
    output logic [HV_W-1:0] hcount,          // x inside the active area, early
    output logic [HV_W-1:0] vcount,          // y inside the active area
    output logic            h_active,
    output logic            v_active,
    output logic            hsync,
    output logic            vsync,
    output logic            frame_start
);

    localparam int H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
    localparam int H_START = H_SYNC + H_BACK;   // sync comes first on every line
    localparam int V_START = V_SYNC + V_BACK;
    localparam int V_END   = V_START + V_ACTIVE;   // first line of the front porch
    localparam int PIPE    = 3;              // depth of the fetch and color pipeline

    logic [HV_W-1:0] h;
    logic [HV_W-1:0] v;
    logic [PIPE-1:0] hs_pipe;
    logic [PIPE-1:0] vs_pipe;
    logic [PIPE-1:0] fs_pipe;

    always_ff @(posedge pxclk) begin
        if (reset) begin
            h <= '0;                         // start of the sync line
            v <= '0;
        end else if (h == HV_W'(H_TOTAL - 1)) begin
            h <= '0;
            v <= (v == HV_W'(V_TOTAL - 1)) ? '0 : v + 1'b1;
        end else begin
            h <= h + 1'b1;
        end
    end

    // the fetch sees these PIPE clocks before the pixel leaves
    assign hcount   = h - HV_W'(H_START);
    assign vcount   = v - HV_W'(V_START);
    assign h_active = (h >= HV_W'(H_START)) && (h < HV_W'(H_START + H_ACTIVE));
    assign v_active = (v >= HV_W'(V_START)) && (v < HV_W'(V_END));

    // ********************************************************************
    // syncs and frame pulse, delayed to line up with color
    // ********************************************************************
    always_ff @(posedge pxclk) begin
        if (reset) begin
            hs_pipe <= '0;
            vs_pipe <= '0;
            fs_pipe <= '0;
        end else begin
            hs_pipe <= {hs_pipe[PIPE-2:0], h < HV_W'(H_SYNC)};
            vs_pipe <= {vs_pipe[PIPE-2:0], v < HV_W'(V_SYNC)};
            fs_pipe <= {fs_pipe[PIPE-2:0], (v == HV_W'(V_END)) && (h == '0)};
        end
    end

    assign hsync       = hs_pipe[PIPE-1];
    assign vsync       = vs_pipe[PIPE-1];
    assign frame_start = fs_pipe[PIPE-1];    // first clock after the last active line

endmodule

// File: design/pixel_fetch.sv
// ********************************************************************
// bitmap fetch and pixel color
// ********************************************************************

`timescale 1ns/1ps

module pixel_fetch import vdp_pkg::*; #(
    parameter int H_ACTIVE = 256,
    parameter int VRAM_AW  = 14
) (
    input  logic               pxclk,
    input  logic               reset,
    input  logic [HV_W-1:0]    hcount,
    input  logic [HV_W-1:0]    vcount,
    input  logic               h_active,
    input  logic               v_active,
    input  logic               display_on,
    input  color_t             backdrop,
    input  logic               fetch_gnt,
    input  logic               fetch_ack,
    input  logic [7:0]         vram_rdata,
    output logic               fetch_req,
    output logic [VRAM_AW-1:0] fetch_addr,
    output color_t             color
);

    localparam int LINE_BYTES = H_ACTIVE / 2;   // two pixels in every byte

    logic       active;
    logic       want;
    logic [1:0] act_pipe;                    // active flag, following the fetch
    color_t     lo_nib;                      // odd pixel of the last byte
    color_t     nib;

    assign active = h_active & v_active;
    assign want   = active & ~hcount[0];     // one fetch per pixel pair

    always_ff @(posedge pxclk) begin
        if (reset) begin
            fetch_req <= 1'b0;
            act_pipe  <= '0;
            color     <= '0;
        end else begin
            if (want) begin
                fetch_req <= 1'b1;
            end else if (fetch_gnt) begin
                fetch_req <= 1'b0;           // at most every second clock
            end
            act_pipe <= {act_pipe[0], active};

            // a zero nibble is transparent and lets the backdrop through
            if (act_pipe[1] && display_on && nib != '0) begin
                color <= nib;
            end else begin
                color <= backdrop;
            end
        end
    end

    always_ff @(posedge pxclk) begin
        if (want) begin
            fetch_addr <= VRAM_AW'(vcount * LINE_BYTES + (hcount >> 1));
        end
        if (fetch_ack) begin
            lo_nib <= vram_rdata[3:0];       // shown on the clock after the high one
        end
    end

    // the ack lands exactly on the even pixel, the odd one uses the saved half
    assign nib = fetch_ack ? vram_rdata[7:4] : lo_nib;

endmodule

// File: design/z80_vdp.sv
// ********************************************************************
// z80 bitmap vdp top level
// ********************************************************************

`timescale 1ns/1ps

module z80_vdp import vdp_pkg::*; #(
    parameter int VRAM_AW  = 14,
    parameter int H_ACTIVE = 256,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 32,
    parameter int H_BACK   = 38,
    parameter int V_ACTIVE = 128,
    parameter int V_FRONT  = 24,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 13,
    parameter int SYN_LEN  = 3
) (
    input  logic      pxclk,
    input  logic      reset,
    input  logic      cpu_mode,
    input  vdp_byte_t cpu_din,
    output vdp_byte_t cpu_dout,
    input  logic      cpu_wr,                // async, from the z80 io decode
    input  logic      cpu_rd,
    output color_t    color,
    output logic      hsync,
    output logic      vsync,
    output logic      irq
);

    logic               wr_tick;
    logic               rd_tick;
    logic               mode;
    vdp_byte_t          din;
    vdp_byte_t          dout;
    logic               frame_start;
    logic               display_on;
    color_t             backdrop;
    logic               port_req;
    logic               port_we;
    logic               port_gnt;
    logic               port_ack;
    logic [VRAM_AW-1:0] port_addr;
    logic [7:0]         port_wdata;
    logic               fetch_req;
    logic               fetch_gnt;
    logic               fetch_ack;
    logic [VRAM_AW-1:0] fetch_addr;
    logic [7:0]         vram_rdata;
    logic [HV_W-1:0]    hcount;
    logic [HV_W-1:0]    vcount;
    logic               h_active;
    logic               v_active;

    cpu_bus_sync #(
        .SYN_LEN (SYN_LEN)
    ) cpu_bus_sync_inst (
        .pxclk    (pxclk),
        .reset    (reset),
        .cpu_mode (cpu_mode),
        .cpu_din  (cpu_din),
        .cpu_wr   (cpu_wr),
        .cpu_rd   (cpu_rd),
        .dout     (dout),
        .cpu_dout (cpu_dout),
        .wr_tick  (wr_tick),
        .rd_tick  (rd_tick),
        .mode     (mode),
        .din      (din)
    );

    vdp_port #(
        .VRAM_AW (VRAM_AW)
    ) vdp_port_inst (
        .pxclk       (pxclk),
        .reset       (reset),
        .wr_tick     (wr_tick),
        .rd_tick     (rd_tick),
        .mode        (mode),
        .din         (din),
        .frame_start (frame_start),
        .port_gnt    (port_gnt),
        .port_ack    (port_ack),
        .vram_rdata  (vram_rdata),
        .dout        (dout),
        .irq         (irq),
        .port_req    (port_req),
        .port_we     (port_we),
        .port_addr   (port_addr),
        .port_wdata  (port_wdata),
        .display_on  (display_on),
        .backdrop    (backdrop)
    );

    vram_arbiter #(
        .VRAM_AW (VRAM_AW)
    ) vram_arbiter_inst (
        .pxclk      (pxclk),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .port_req   (port_req),
        .port_we    (port_we),
        .port_addr  (port_addr),
        .port_wdata (port_wdata),
        .fetch_gnt  (fetch_gnt),
        .fetch_ack  (fetch_ack),
        .port_gnt   (port_gnt),
        .port_ack   (port_ack),
        .vram_rdata (vram_rdata)
    );

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) video_timing_inst (
        .pxclk       (pxclk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .h_active    (h_active),
        .v_active    (v_active),
        .hsync       (hsync),
        .vsync       (vsync),
        .frame_start (frame_start)
    );

    pixel_fetch #(
        .H_ACTIVE (H_ACTIVE),
        .VRAM_AW  (VRAM_AW)
    ) pixel_fetch_inst (
        .pxclk      (pxclk),
        .reset      (reset),
        .hcount     (hcount),
        .vcount     (vcount),
        .h_active   (h_active),
        .v_active   (v_active),
        .display_on (display_on),
        .backdrop   (backdrop),
        .fetch_gnt  (fetch_gnt),
        .fetch_ack  (fetch_ack),
        .vram_rdata (vram_rdata),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .color      (color)
    );

endmodule

// File: tb/vdp_chk.sv
// ********************************************************************
// vram grant and ack protocol checks
// ********************************************************************

`timescale 1ns/1ps

module vdp_chk (
    input logic pxclk,
    input logic port_req,
    input logic port_gnt,
    input logic port_ack,
    input logic fetch_gnt,
    input logic fetch_ack
);

    // the single vram port serves one requester per clock
    a_one_grant: assert property (@(posedge pxclk) port_gnt |-> !fetch_gnt)
        else $error("port and fetch were granted in the same cycle");

    // read data belongs to whoever was granted on the clock before
    a_port_ack: assert property (@(posedge pxclk) port_gnt |=> port_ack)
        else $error("port grant was not followed by a port ack");
    a_fetch_ack: assert property (@(posedge pxclk) fetch_gnt |=> fetch_ack)
        else $error("fetch grant was not followed by a fetch ack");

    // fetch leaves every other clock free, so a waiting port gets the next one
    a_port_wait: assert property (@(posedge pxclk) (port_req && !port_gnt) |=> port_gnt)
        else $error("port request was not granted within two cycles");

endmodule

// File: tb/tb_z80_vdp.sv
// ********************************************************************
// z80 vdp testbench
// ********************************************************************

`timescale 1ns/1ps

module tb_z80_vdp import vdp_pkg::*;;

    localparam int VRAM_AW  = 8;
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 1;
    localparam int V_BACK   = 2;
    localparam int H_TOTAL  = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL  = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
    localparam int FRAME    = H_TOTAL * V_TOTAL;
    localparam int H_FIRST  = H_SYNC + H_BACK;        // first active column after hsync rise
    localparam int V_FIRST  = V_SYNC + V_BACK;        // first active line after the vsync line
    localparam int V_AFTER  = V_FIRST + V_ACTIVE;     // line where the frame flag is set
    // bus operations in all scenarios, the cycles one can take, and the frames waited
    localparam int NUM_OPS    = 160;
    localparam int OP_CYCLES  = 26;
    localparam int NUM_FRAMES = 16;
    localparam int LIMIT      = 20 + NUM_OPS * OP_CYCLES + NUM_FRAMES * FRAME;

    logic      pxclk;
    logic      reset;
    logic      cpu_mode;
    vdp_byte_t cpu_din;
    vdp_byte_t cpu_dout;
    logic      cpu_wr;
    logic      cpu_rd;
    color_t    color;
    logic      hsync;
    logic      vsync;
    logic      irq;

    // reference model of vram, registers, pointer and read-ahead
    logic [7:0] vram_m [256];
    logic [7:0] ctrl_m;
    logic [7:0] bd_m;
    logic [7:0] ptr_m;
    logic [7:0] ra_m;

    bit check_color;                          // compare color against the bitmap rule
    bit irq_watch;                            // check where irq rises
    bit passed;
    bit fail_shown;

    z80_vdp #(
        .VRAM_AW (VRAM_AW), .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC),
        .H_BACK (H_BACK), .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC),
        .V_BACK (V_BACK), .SYN_LEN (3)
    ) z80_vdp_inst (
        .pxclk (pxclk), .reset (reset), .cpu_mode (cpu_mode), .cpu_din (cpu_din),
        .cpu_dout (cpu_dout), .cpu_wr (cpu_wr), .cpu_rd (cpu_rd), .color (color),
        .hsync (hsync), .vsync (vsync), .irq (irq)
    );

    bind vram_arbiter vdp_chk arb_chk_inst (
        .pxclk (pxclk), .port_req (port_req), .port_gnt (port_gnt), .port_ack (port_ack),
        .fetch_gnt (fetch_gnt), .fetch_ack (fetch_ack)
    );

    always #5 pxclk = ~pxclk;

    task automatic stop_on_error(input string msg);
        fail_shown = 1'b1;
        $display("Checks failed");
        $display("%s", msg);
        $fatal(1, "stopped at the first failing check");
    endtask

    // ********************************************************************
    // cpu bus driver, one strobe with random width and gap
    // ********************************************************************
    task automatic bus_cycle(input logic m, input logic [7:0] d, input bit rd,
                             output logic [7:0] q);
        int width;
        int gap;
        width = 4 + int'($urandom % 5);
        gap   = 12 + int'($urandom % 4);
        @(negedge pxclk);
        cpu_mode = m;
        cpu_din  = d;
        if (rd) cpu_rd = 1'b1;
        else cpu_wr = 1'b1;
        repeat (width) @(negedge pxclk);
        cpu_wr = 1'b0;
        cpu_rd = 1'b0;
        @(posedge pxclk);
        q = cpu_dout;                         // captured well before the strobe fell
        repeat (gap) @(negedge pxclk);
    endtask

    task automatic ctrl_pair(input logic [7:0] first, input logic [7:0] second);
        logic [7:0] q;
        bus_cycle(1'b1, first, 1'b0, q);
        bus_cycle(1'b1, second, 1'b0, q);
    endtask

    task automatic write_reg(input logic [2:0] idx, input logic [7:0] val);
        ctrl_pair(val, 8'h80 | 8'(idx));
        if (idx == REG_CTRL) ctrl_m = val;
        if (idx == REG_BACKDROP) bd_m = val;
    endtask

    task automatic write_setup(input logic [7:0] a);
        ctrl_pair(a, 8'h40);
        ptr_m = a;
    endtask

    task automatic read_setup(input logic [7:0] a);
        ctrl_pair(a, 8'h00);
        ra_m  = vram_m[a];                    // setup prefetches and steps past the byte
        ptr_m = a + 8'd1;
    endtask

    task automatic data_write(input logic [7:0] d);
        logic [7:0] q;
        bus_cycle(1'b0, d, 1'b0, q);
        vram_m[ptr_m] = d;
        ptr_m = ptr_m + 8'd1;
    endtask

    task automatic data_read();
        logic [7:0] q;
        bus_cycle(1'b0, 8'h00, 1'b1, q);
        assert (q == ra_m) else stop_on_error($sformatf(
            "FAILED cpu_dout: got %h expected %h at vram %h", q, ra_m, ptr_m - 8'd1));
        ra_m  = vram_m[ptr_m];
        ptr_m = ptr_m + 8'd1;
    endtask

    task automatic status_read(input bit check, input logic [7:0] exp);
        logic [7:0] q;
        bus_cycle(1'b1, 8'h00, 1'b1, q);
        if (check) begin
            assert (q == exp) else stop_on_error($sformatf(
                "FAILED cpu_dout status: got %h expected %h", q, exp));
        end
    endtask

    task automatic wait_vsync();
        @(negedge pxclk);
        while (!vsync) @(negedge pxclk);     // start of the sync line
        while (vsync) @(negedge pxclk);
    endtask

    task automatic check_frame();
        @(posedge pxclk);
        check_color = 1'b1;
        repeat (2 * FRAME) @(posedge pxclk);
        check_color = 1'b0;
    endtask

    // bitmap rule, line and col counted from the rising hsync of the sync line
    function automatic color_t expected_color(input int line, input int col);
        int x;
        int y;
        logic [7:0] b;
        color_t nib;
        x = col - H_FIRST;
        y = line - V_FIRST;
        if (x < 0 || x >= H_ACTIVE || y < 0 || y >= V_ACTIVE || !ctrl_m[CTRL_BLANK_N]) begin
            return bd_m[3:0];
        end
        b   = vram_m[8'(y * (H_ACTIVE / 2) + x / 2)];
        nib = x[0] ? b[3:0] : b[7:4];
        return (nib != 4'h0) ? nib : bd_m[3:0];
    endfunction

    // ********************************************************************
    // raster monitor, sampled on the falling edge where outputs are stable
    // ********************************************************************
    int col, line, hper, hwid, vper, vwid;
    bit hs_seen, vs_seen, hs_prev, vs_prev, irq_prev;

    always @(negedge pxclk) begin
        if (reset) begin
            hs_seen = 1'b0;
            vs_seen = 1'b0;
            hs_prev = 1'b0;
            vs_prev = 1'b0;
            irq_prev = 1'b0;
            hwid = 0;
            vwid = 0;
        end else begin
            if (hsync && !hs_prev) begin
                if (hs_seen) begin
                    assert (hper == H_TOTAL) else stop_on_error($sformatf(
                        "FAILED hsync period: got %h expected %h", hper, H_TOTAL));
                end
                hs_seen = 1'b1;
                hper = 1;
                col  = 0;
                line = vsync ? 0 : line + 1;  // vsync and hsync rise together
            end else begin
                hper = hper + 1;
                col  = col + 1;
            end
            if (hsync) hwid = hwid + 1;
            else if (hs_prev) begin
                assert (hwid == H_SYNC) else stop_on_error($sformatf(
                    "FAILED hsync width: got %h expected %h", hwid, H_SYNC));
                hwid = 0;
            end
            if (vsync && !vs_prev) begin
                if (vs_seen) begin
                    assert (vper == FRAME) else stop_on_error($sformatf(
                        "FAILED vsync period: got %h expected %h", vper, FRAME));
                end
                vs_seen = 1'b1;
                vper = 1;
            end else vper = vper + 1;
            if (vsync) vwid = vwid + 1;
            else if (vs_prev) begin
                assert (vwid == V_SYNC * H_TOTAL) else stop_on_error($sformatf(
                    "FAILED vsync width: got %h expected %h", vwid, V_SYNC * H_TOTAL));
                vwid = 0;
            end
            if (check_color && vs_seen) begin
                assert (color == expected_color(line, col)) else stop_on_error($sformatf(
                    "FAILED color: got %h expected %h at line %h col %h",
                    color, expected_color(line, col), line, col));
            end
            if (irq_watch && irq && !irq_prev) begin
                assert (line == V_AFTER && col < H_SYNC) else stop_on_error($sformatf(
                    "FAILED irq rise: line %h col %h expected line %h", line, col, V_AFTER));
            end
            hs_prev  = hsync;
            vs_prev  = vsync;
            irq_prev = irq;
        end
    end

    initial begin
        repeat (LIMIT) @(posedge pxclk);
        fail_shown = 1'b1;
        $display("Checks failed");
        $fatal(1, "the run did not finish within %0d cycles", LIMIT);
    end

    final begin
        if (!passed && !fail_shown) $display("Checks failed");
    end

    // ********************************************************************
    // scenarios
    // ********************************************************************
    initial begin
        logic [7:0] base;
        logic [7:0] d;
        pxclk = 1'b0;
        reset = 1'b1;
        cpu_mode = 1'b0;
        cpu_din = 8'h00;
        cpu_wr = 1'b0;
        cpu_rd = 1'b0;
        ctrl_m = 8'h00;
        bd_m = 8'h00;
        ptr_m = 8'h00;
        ra_m = 8'h00;
        foreach (vram_m[i]) vram_m[i] = 8'h00;
        void'($urandom(32'hd5d4));

        // reset holds the outputs quiet, then a blank first line
        for (int i = 0; i < 10; i++) begin
            @(negedge pxclk);
            if (i >= 2) begin
                assert (!irq && !hsync && !vsync && cpu_dout == 8'h00) else stop_on_error(
                    $sformatf("FAILED reset outputs: irq %h hsync %h vsync %h cpu_dout %h",
                              irq, hsync, vsync, cpu_dout));
            end
        end
        reset = 1'b0;
        repeat (H_TOTAL) begin
            @(negedge pxclk);
            assert (color == 4'h0) else stop_on_error($sformatf(
                "FAILED color after reset: got %h expected %h", color, 4'h0));
        end

        // random block written and read back through the read-ahead
        base = 8'($urandom);
        write_setup(base);
        repeat (12) data_write(8'($urandom));
        read_setup(base);
        repeat (12) data_read();

        // bitmap with some transparent nibbles, blanked then shown
        write_setup(8'h00);
        for (int i = 0; i < V_ACTIVE * H_ACTIVE / 2; i++) begin
            d = 8'($urandom);
            if (i % 4 == 0) d = d & 8'h0f;
            if (i % 4 == 1) d = d & 8'hf0;
            data_write(d);
        end
        write_reg(REG_BACKDROP, 8'(1 + $urandom % 15));
        check_frame();
        write_reg(REG_CTRL, 8'h40);
        check_frame();

        // interrupt at the end of the active area, cleared by a status read
        write_reg(REG_CTRL, 8'h60);
        wait_vsync();
        status_read(1'b0, 8'h00);            // drop any stale flag
        irq_watch = 1'b1;
        @(negedge pxclk);
        while (!irq) @(negedge pxclk);
        @(posedge pxclk);                    // the monitor has seen the rising irq by now
        irq_watch = 1'b0;
        status_read(1'b1, 8'h80);
        assert (!irq) else stop_on_error($sformatf("FAILED irq: got %h expected %h", irq, 0));
        status_read(1'b1, 8'h00);
        write_reg(REG_CTRL, 8'h40);

        // writes while the fetch owns every other vram cycle
        wait_vsync();
        repeat (V_FIRST * H_TOTAL) @(negedge pxclk);
        base = 8'($urandom);
        write_setup(base);
        repeat (10) data_write(8'($urandom));
        wait_vsync();
        read_setup(base);
        repeat (10) data_read();
        check_frame();

        passed = 1'b1;
        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog.f
design/vdp_pkg.sv
design/cpu_bus_sync.sv
design/vdp_port.sv
design/vram_arbiter.sv
design/video_timing.sv
design/pixel_fetch.sv
design/z80_vdp.sv
tb/vdp_chk.sv
tb/tb_z80_vdp.sv

// File: run.sh
#!/bin/sh
# build and run the z80 vdp testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_z80_vdp -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_z80_vdp)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
